//--- verilog/cpuPkg.sv
package cpuPkg;

    // ALU operations. The encodings follow the instruction set, so the gaps
    // belong to load, store and the immediate logic forms.
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opShr  = 5'b00101,
        opShra = 5'b00110,
        opShl  = 5'b00111,
        opRor  = 5'b01000,
        opRol  = 5'b01001,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opMul  = 5'b01111,
        opDiv  = 5'b10000,
        opNeg  = 5'b10001,
        opNot  = 5'b10010
    } aluOp_e;

    // bus source selects, listed in bus priority order.
    typedef struct packed {
        logic hiOut;
        logic loOut;
        logic zHiOut;
        logic zLoOut;
        logic pcOut;
        logic mdrOut;
        logic inportOut;
        logic cOut;
        logic rOut;
    } busSources_t;

    // register load enables.
    typedef struct packed {
        logic marIn;
        logic zIn;
        logic pcIn;
        logic mdrIn;
        logic irIn;
        logic yIn;
        logic hiIn;
        logic loIn;
        logic conIn;
        logic outportIn;
        logic rIn;
    } regLoads_t;

    // choice of IR register field, plus r0 base-address zeroing.
    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
        logic baOut;
    } regSelect_t;

    typedef struct packed {
        logic read;
        logic write;
        logic enable;
    } memCtrl_t;

endpackage

//--- verilog/ram512x32.sv
module ram512x32 #(
    parameter int dataWidth = 32,
    parameter int addrWidth = 9
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  cpuPkg::memCtrl_t     memCtrl,
    input  logic [addrWidth-1:0] address,
    input  logic [dataWidth-1:0] dataIn,
    output logic [dataWidth-1:0] dataOut,
    output logic                 done,
    input  logic                 override,
    input  logic [addrWidth-1:0] overrideAddress,
    input  logic [dataWidth-1:0] overrideData
);

    logic [dataWidth-1:0] mem [2**addrWidth];
    logic                 accessWrite;
    logic                 accessRead;

    // a preload on the override port masks any normal access in that cycle.
    assign accessWrite = !override && memCtrl.enable && memCtrl.write;
    assign accessRead  = !override && memCtrl.enable && memCtrl.read && !memCtrl.write;

    always_ff @(posedge Clock) begin
        if (override) begin
            mem[overrideAddress] <= overrideData;
        end else if (accessWrite) begin
            mem[address] <= dataIn;
        end
    end

    // done rises for one cycle after each normal request. the read word
    // stays on dataOut until the next read.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            dataOut <= '0;
            done    <= 1'b0;
        end else begin
            done <= accessWrite || accessRead;
            if (accessRead) begin
                dataOut <= mem[address];
            end
        end
    end

endmodule

//--- verilog/registerFile.sv
module registerFile #(
    parameter int dataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [dataWidth-1:0] ir,
    input  cpuPkg::regSelect_t   regSelect,
    input  logic                 write,
    input  logic [dataWidth-1:0] busIn,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] regs [16];
    logic [3:0]           index;

    // Ra sits at 26:23, Rb at 22:19 and Rc at 18:15 of the instruction.
    always_comb begin
        if (regSelect.gra)      index = ir[26:23];
        else if (regSelect.grb) index = ir[22:19];
        else if (regSelect.grc) index = ir[18:15];
        else                    index = 4'd0;
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[index] <= busIn;
        end
    end

    // under baOut, r0 reads as zero so it can serve as a null base register.
    assign readData = (regSelect.baOut && index == 4'd0) ? '0 : regs[index];

endmodule

//--- verilog/alu.sv
module alu #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0]   y,
    input  logic [dataWidth-1:0]   busIn,
    input  cpuPkg::aluOp_e         aluOp,
    input  logic                   incPc,
    output logic [2*dataWidth-1:0] result
);

    import cpuPkg::*;

    logic [4:0]                    shamt;
    logic signed [2*dataWidth-1:0] product;
    logic signed [dataWidth-1:0]   quotient;
    logic signed [dataWidth-1:0]   remainder;
    logic [dataWidth-1:0]          lowResult;

    assign shamt = busIn[4:0];

    // both operands are signed, so the product is sign-extended to full width.
    assign product = $signed(y) * $signed(busIn);

    // a zero divisor yields zero for both halves rather than an unknown value.
    always_comb begin
        if (busIn == '0) begin
            quotient  = '0;
            remainder = '0;
        end else begin
            quotient  = $signed(y) / $signed(busIn);
            remainder = $signed(y) % $signed(busIn);
        end
    end

    always_comb begin
        case (aluOp)
            opAdd, opAddi: lowResult = y + busIn;
            opSub:         lowResult = y - busIn;
            opAnd:         lowResult = y & busIn;
            opOr:          lowResult = y | busIn;
            opShr:         lowResult = y >> shamt;
            opShra:        lowResult = $signed(y) >>> shamt;
            opShl:         lowResult = y << shamt;
            opRor:         lowResult = (y >> shamt) | (y << (dataWidth - shamt));
            opRol:         lowResult = (y << shamt) | (y >> (dataWidth - shamt));
            opNeg:         lowResult = -busIn;
            opNot:         lowResult = ~busIn;
            default:       lowResult = '0;
        endcase
    end

    // PC increment overrides the opcode. single-width results leave Z high clear.
    always_comb begin
        if (incPc) begin
            result = {{dataWidth{1'b0}}, busIn + 1'b1};
        end else if (aluOp == opMul) begin
            result = product;
        end else if (aluOp == opDiv) begin
            result = {remainder, quotient};
        end else begin
            result = {{dataWidth{1'b0}}, lowResult};
        end
    end

endmodule

//--- verilog/conditionLogic.sv
module conditionLogic (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [1:0]  condField,
    input  logic [31:0] busIn,
    input  logic        load,
    output logic        conFf
);

    logic isZero;
    logic isNegative;
    logic condMet;

    assign isZero     = (busIn == 32'd0);
    assign isNegative = busIn[31];

    // 0 branches on zero, 1 on nonzero, 2 on positive, 3 on negative.
    always_comb begin
        case (condField)
            2'd0:    condMet = isZero;
            2'd1:    condMet = !isZero;
            2'd2:    condMet = !isNegative && !isZero;
            default: condMet = isNegative;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            conFf <= 1'b0;
        end else if (load) begin
            conFf <= condMet;
        end
    end

endmodule

//--- verilog/ioPorts.sv
module ioPorts #(
    parameter int dataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [dataWidth-1:0] inportData,
    input  logic                 inportStrobe,
    output logic [dataWidth-1:0] inportValue,
    input  logic                 outportLoad,
    input  logic [dataWidth-1:0] busIn,
    output logic [dataWidth-1:0] outportData
);

    // input register samples the pins only when the device strobes.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            inportValue <= '0;
        end else if (inportStrobe) begin
            inportValue <= inportData;
        end
    end

    // the output register holds its value on the pins until reloaded from the bus.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            outportData <= '0;
        end else if (outportLoad) begin
            outportData <= busIn;
        end
    end

endmodule

//--- verilog/dataPath.sv
module dataPath #(
    parameter int dataWidth = 32,
    parameter int addrWidth = 9
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  cpuPkg::busSources_t  busSources,
    input  cpuPkg::regLoads_t    regLoads,
    input  cpuPkg::regSelect_t   regSelect,
    input  cpuPkg::aluOp_e       aluOp,
    input  logic                 incPc,
    input  logic                 memRead,
    input  logic [dataWidth-1:0] memDataIn,
    output logic [addrWidth-1:0] marAddress,
    output logic [dataWidth-1:0] memDataOut,
    input  logic [dataWidth-1:0] inportData,
    input  logic                 inportStrobe,
    output logic [dataWidth-1:0] outportData,
    output logic                 conFf
);

    logic [dataWidth-1:0]   bus;
    logic [dataWidth-1:0]   pc, ir, y, hi, lo, mdr;
    logic [2*dataWidth-1:0] z;
    logic [addrWidth-1:0]   mar;
    logic [2*dataWidth-1:0] aluResult;
    logic [dataWidth-1:0]   regData;
    logic [dataWidth-1:0]   inportValue;
    logic [dataWidth-1:0]   constValue;

    // the constant field of IR is 19 bits and is sign-extended onto the bus.
    assign constValue = {{(dataWidth-19){ir[18]}}, ir[18:0]};

    // shared bus. the first active select wins, and nothing selected reads as zero.
    always_comb begin
        if (busSources.hiOut)          bus = hi;
        else if (busSources.loOut)     bus = lo;
        else if (busSources.zHiOut)    bus = z[2*dataWidth-1:dataWidth];
        else if (busSources.zLoOut)    bus = z[dataWidth-1:0];
        else if (busSources.pcOut)     bus = pc;
        else if (busSources.mdrOut)    bus = mdr;
        else if (busSources.inportOut) bus = inportValue;
        else if (busSources.cOut)      bus = constValue;
        else if (busSources.rOut)      bus = regData;
        else                           bus = '0;
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc  <= '0;
            ir  <= '0;
            y   <= '0;
            z   <= '0;
            hi  <= '0;
            lo  <= '0;
            mar <= '0;
            mdr <= '0;
        end else begin
            if (regLoads.pcIn)  pc  <= bus;
            if (regLoads.irIn)  ir  <= bus;
            if (regLoads.yIn)   y   <= bus;
            if (regLoads.zIn)   z   <= aluResult;
            if (regLoads.hiIn)  hi  <= bus;
            if (regLoads.loIn)  lo  <= bus;
            if (regLoads.marIn) mar <= bus[addrWidth-1:0];
            // MDR takes the memory word during a read, the bus otherwise.
            if (regLoads.mdrIn) mdr <= memRead ? memDataIn : bus;
        end
    end

    assign marAddress = mar;
    assign memDataOut = mdr;

    registerFile #(
        .dataWidth(dataWidth)
    ) registerFile (
        .Clock    (Clock),
        .rstN     (rstN),
        .ir       (ir),
        .regSelect(regSelect),
        .write    (regLoads.rIn),
        .busIn    (bus),
        .readData (regData)
    );

    alu #(
        .dataWidth(dataWidth)
    ) alu (
        .y     (y),
        .busIn (bus),
        .aluOp (aluOp),
        .incPc (incPc),
        .result(aluResult)
    );

    // branch conditions live in the Rb field position of IR.
    conditionLogic conditionLogic (
        .Clock    (Clock),
        .rstN     (rstN),
        .condField(ir[20:19]),
        .busIn    (bus),
        .load     (regLoads.conIn),
        .conFf    (conFf)
    );

    ioPorts #(
        .dataWidth(dataWidth)
    ) ioPorts (
        .Clock       (Clock),
        .rstN        (rstN),
        .inportData  (inportData),
        .inportStrobe(inportStrobe),
        .inportValue (inportValue),
        .outportLoad (regLoads.outportIn),
        .busIn       (bus),
        .outportData (outportData)
    );

endmodule

//--- verilog/system.sv
module system #(
    parameter int dataWidth = 32,
    parameter int addrWidth = 9
) (
    input  logic                 Clock,
    input  logic                 rstN,

    // control bundles, driven directly by the test environment.
    input  cpuPkg::busSources_t  busSources,
    input  cpuPkg::regLoads_t    regLoads,
    input  cpuPkg::regSelect_t   regSelect,
    input  cpuPkg::aluOp_e       aluOp,
    input  logic                 incPc,
    input  cpuPkg::memCtrl_t     memCtrl,

    // external ports.
    input  logic [dataWidth-1:0] inportData,
    input  logic                 inportStrobe,
    output logic [dataWidth-1:0] outportData,
    output logic                 conFf,

    // memory preload port.
    input  logic                 override,
    input  logic [addrWidth-1:0] overrideAddress,
    input  logic [dataWidth-1:0] overrideData,

    // memory buses, brought out for observation.
    output logic [addrWidth-1:0] marAddress,
    output logic [dataWidth-1:0] memDataIn,
    output logic [dataWidth-1:0] memDataOut,
    output logic                 memDone
);

    dataPath #(
        .dataWidth(dataWidth),
        .addrWidth(addrWidth)
    ) dataPath (
        .Clock       (Clock),
        .rstN        (rstN),
        .busSources  (busSources),
        .regLoads    (regLoads),
        .regSelect   (regSelect),
        .aluOp       (aluOp),
        .incPc       (incPc),
        .memRead     (memCtrl.read),
        .memDataIn   (memDataIn),
        .marAddress  (marAddress),
        .memDataOut  (memDataOut),
        .inportData  (inportData),
        .inportStrobe(inportStrobe),
        .outportData (outportData),
        .conFf       (conFf)
    );

    // the memory reads and writes at whatever MAR currently holds.
    ram512x32 #(
        .dataWidth(dataWidth),
        .addrWidth(addrWidth)
    ) memory (
        .Clock          (Clock),
        .rstN           (rstN),
        .memCtrl        (memCtrl),
        .address        (marAddress),
        .dataIn         (memDataOut),
        .dataOut        (memDataIn),
        .done           (memDone),
        .override       (override),
        .overrideAddress(overrideAddress),
        .overrideData   (overrideData)
    );

endmodule

//--- verification/systemTb.sv
module systemTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    // the full sequence runs for about five hundred cycles, so this leaves a wide margin.
    localparam int cycleLimit = 4000;

    localparam busSources_t fromInport = '{inportOut: 1'b1, default: 1'b0};
    localparam busSources_t fromReg    = '{rOut: 1'b1, default: 1'b0};
    localparam busSources_t fromZLo    = '{zLoOut: 1'b1, default: 1'b0};
    localparam busSources_t fromZHi    = '{zHiOut: 1'b1, default: 1'b0};
    localparam busSources_t fromHi     = '{hiOut: 1'b1, default: 1'b0};
    localparam busSources_t fromLo     = '{loOut: 1'b1, default: 1'b0};
    localparam busSources_t fromMdr    = '{mdrOut: 1'b1, default: 1'b0};
    localparam busSources_t fromConst  = '{cOut: 1'b1, default: 1'b0};
    localparam regLoads_t   toY        = '{yIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toZ        = '{zIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toIr       = '{irIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toReg      = '{rIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toOut      = '{outportIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toMar      = '{marIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toMdr      = '{mdrIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toHi       = '{hiIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toLo       = '{loIn: 1'b1, default: 1'b0};
    localparam regLoads_t   toCon      = '{conIn: 1'b1, default: 1'b0};

    logic        Clock;
    logic        rstN;
    busSources_t busSources;
    regLoads_t   regLoads;
    regSelect_t  regSelect;
    aluOp_e      aluOp;
    logic        incPc;
    memCtrl_t    memCtrl;
    logic [31:0] inportData;
    logic        inportStrobe;
    logic [31:0] outportData;
    logic        conFf;
    logic        override;
    logic [8:0]  overrideAddress;
    logic [31:0] overrideData;
    logic [8:0]  marAddress;
    logic [31:0] memDataIn;
    logic [31:0] memDataOut;
    logic        memDone;

    integer      seed = 39610;
    int          errors = 0;
    int          checks = 0;
    int          cycleCount = 0;
    logic [31:0] regModel [16];
    logic [31:0] memModel [512];

    system #(.dataWidth(32), .addrWidth(9)) i_dut (.*);

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    always @(posedge Clock) cycleCount <= cycleCount + 1;

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("Timeout: the run did not finish within %0d cycles.", cycleLimit);
        $display("Test failed");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // one bus cycle from a single source into the given registers.
    task automatic transfer(input busSources_t src, input regLoads_t ld);
        busSources = src;
        regLoads   = ld;
        @(posedge Clock);
        #1;
        busSources = '0;
        regLoads   = '0;
    endtask

    // a word enters through the input port, then crosses the bus.
    task automatic driveWord(input logic [31:0] word, input regLoads_t ld);
        inportData   = word;
        inportStrobe = 1'b1;
        @(posedge Clock);
        #1;
        inportStrobe = 1'b0;
        transfer(fromInport, ld);
    endtask

    function automatic logic [63:0] aluModel(aluOp_e op, logic [31:0] a, logic [31:0] b);
        logic [4:0]         s;
        logic [63:0]        shifted;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] q;
        logic signed [63:0] r;
        s  = b[4:0];
        sa = $signed(a);
        sb = $signed(b);
        q  = (b == 0) ? 64'sd0 : sa / sb;
        r  = (b == 0) ? 64'sd0 : sa % sb;
        case (op)
            opAdd, opAddi: return {32'd0, a + b};
            opSub:         return {32'd0, a - b};
            opAnd:         return {32'd0, a & b};
            opOr:          return {32'd0, a | b};
            opShr:         return {32'd0, a >> s};
            opShra:        return {32'd0, $signed(a) >>> s};
            opShl:         return {32'd0, a << s};
            opRor: begin
                shifted = {a, a} >> s;
                return {32'd0, shifted[31:0]};
            end
            opRol: begin
                shifted = {a, a} << s;
                return {32'd0, shifted[63:32]};
            end
            opMul:         return sa * sb;
            opDiv:         return {r[31:0], q[31:0]};
            opNeg:         return {32'd0, ~b + 32'd1};
            opNot:         return {32'd0, ~b};
            default:       return 64'd0;
        endcase
    endfunction

    task automatic registerTransfer;
        logic [31:0] data;
        regSelect = '{gra: 1'b1, default: 1'b0};
        for (int k = 0; k < 16; k++) begin
            data = $random(seed);
            driveWord(k << 23, toIr);
            driveWord(data, toReg);
            regModel[k] = data;
            transfer(fromReg, toOut);
            checkValue("registerWrite", data, outportData);
        end
        // a second pass through Rb catches a write that landed in the wrong register.
        regSelect = '{grb: 1'b1, default: 1'b0};
        for (int k = 0; k < 16; k++) begin
            driveWord(k << 19, toIr);
            transfer(fromReg, toOut);
            checkValue("registerReadBack", regModel[k], outportData);
        end
        regSelect = '{grc: 1'b1, baOut: 1'b1, default: 1'b0};
        driveWord(32'd0, toIr);
        transfer(fromReg, toOut);
        checkValue("baseZero", 32'd0, outportData);
        regSelect = '0;
    endtask

    task automatic aluOperations;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected;
        aluOp_e      op;
        op = op.first();
        do begin
            for (int t = 0; t < 3; t++) begin
                a = $random(seed);
                b = $random(seed);
                if (op == opDiv && b == 32'd0) b = 32'd7;
                aluOp = op;
                driveWord(a, toY);
                driveWord(b, toZ);
                expected = aluModel(op, a, b);
                transfer(fromZLo, toOut);
                checkValue(op.name(), expected[31:0], outportData);
                if (op == opMul || op == opDiv) begin
                    transfer(fromZHi, toHi);
                    transfer(fromZLo, toLo);
                    transfer(fromHi, toOut);
                    checkValue({op.name(), "High"}, expected[63:32], outportData);
                    transfer(fromLo, toOut);
                    checkValue({op.name(), "Low"}, expected[31:0], outportData);
                end
            end
            op = op.next();
        end while (op != op.first());
        b = $random(seed);
        incPc = 1'b1;
        driveWord(b, toZ);
        incPc = 1'b0;
        transfer(fromZLo, toOut);
        checkValue("incPc", b + 32'd1, outportData);
    endtask

    task automatic readWord(input logic [8:0] addr, input string name);
        driveWord({23'd0, addr}, toMar);
        checkValue({name, "Address"}, {23'd0, addr}, {23'd0, marAddress});
        checkValue({name, "DoneIdle"}, 32'd0, {31'd0, memDone});
        memCtrl = '{read: 1'b1, write: 1'b0, enable: 1'b1};
        @(posedge Clock);
        #1;
        checkValue({name, "Done"}, 32'd1, {31'd0, memDone});
        checkValue({name, "Data"}, memModel[addr], memDataIn);
        // read stays high so MDR takes the memory word on this edge.
        memCtrl.enable = 1'b0;
        regLoads       = toMdr;
        @(posedge Clock);
        #1;
        memCtrl  = '0;
        regLoads = '0;
        checkValue({name, "DoneEnd"}, 32'd0, {31'd0, memDone});
        transfer(fromMdr, toOut);
        checkValue(name, memModel[addr], outportData);
    endtask

    task automatic memoryAccess;
        logic [8:0]  addrs [4];
        logic [31:0] data;
        addrs = '{9'h005, 9'h0a3, 9'h17c, 9'h1ff};
        foreach (addrs[i]) begin
            override        = 1'b1;
            overrideAddress = addrs[i];
            overrideData    = $random(seed);
            memModel[addrs[i]] = overrideData;
            @(posedge Clock);
            #1;
            override = 1'b0;
        end
        foreach (addrs[i]) begin
            readWord(addrs[i], "memoryRead");
        end
        data = $random(seed);
        driveWord({23'd0, addrs[1]}, toMar);
        driveWord(data, toMdr);
        checkValue("writeData", data, memDataOut);
        memCtrl = '{read: 1'b0, write: 1'b1, enable: 1'b1};
        @(posedge Clock);
        #1;
        memCtrl = '0;
        memModel[addrs[1]] = data;
        checkValue("writeDone", 32'd1, {31'd0, memDone});
        @(posedge Clock);
        #1;
        checkValue("writeDoneEnd", 32'd0, {31'd0, memDone});
        readWord(addrs[1], "memoryReadBack");
    endtask

    task automatic conditionFlag;
        logic [31:0] values [3];
        logic        expected;
        for (int f = 0; f < 4; f++) begin
            driveWord(f << 19, toIr);
            values[0] = ({$random(seed)} & 32'h7fff_ffff) | 32'd1;
            values[1] = $random(seed) | 32'h8000_0000;
            values[2] = 32'd0;
            for (int v = 0; v < 3; v++) begin
                driveWord(values[v], toCon);
                case (f)
                    0:       expected = (values[v] == 32'd0);
                    1:       expected = (values[v] != 32'd0);
                    2:       expected = !values[v][31] && (values[v] != 32'd0);
                    default: expected = values[v][31];
                endcase
                checkValue($sformatf("condition%0d", f), {31'd0, expected}, {31'd0, conFf});
            end
        end
    endtask

    task automatic constantPath;
        logic [18:0] c;
        c = $random(seed);
        c[18] = 1'b1;
        driveWord({13'd0, c}, toIr);
        transfer(fromConst, toOut);
        checkValue("constant", {{13{1'b1}}, c}, outportData);
    endtask

    initial begin
        rstN            = 1'b0;
        busSources      = '0;
        regLoads        = '0;
        regSelect       = '0;
        aluOp           = opAdd;
        incPc           = 1'b0;
        memCtrl         = '0;
        inportData      = '0;
        inportStrobe    = 1'b0;
        override        = 1'b0;
        overrideAddress = '0;
        overrideData    = '0;
        repeat (16) @(posedge Clock);
        #1;
        rstN = 1'b1;
        checkValue("resetOutport", 32'd0, outportData);
        checkValue("resetCon", 32'd0, {31'd0, conFf});
        checkValue("resetDone", 32'd0, {31'd0, memDone});
        checkValue("resetMar", 32'd0, {23'd0, marAddress});
        registerTransfer();
        aluOperations();
        memoryAccess();
        conditionFlag();
        constantPath();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/cpuPkg.sv
verilog/ram512x32.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/conditionLogic.sv
verilog/ioPorts.sv
verilog/dataPath.sv
verilog/system.sv
verification/systemTb.sv

//--- Bender.yml
package:
  name: system

sources:
  - verilog/cpuPkg.sv
  - verilog/ram512x32.sv
  - verilog/registerFile.sv
  - verilog/alu.sv
  - verilog/conditionLogic.sv
  - verilog/ioPorts.sv
  - verilog/dataPath.sv
  - verilog/system.sv
  - target: test
    files:
      - verification/systemTb.sv
